//--- vdp_trace.txt
# Records: W addr data = register write, A word / B word = layer word, E color = expected dot
# D = wait for every expected dot; all values hex
W 3 01
W 4 00
W 5 7C
W 4 E0
W 5 03
W 3 11
W 4 21
W 5 84
W 4 10
W 5 42
W 4 55
W 5 2A
W 1 10
W 2 13
A 12002010
B 20101200
E 7C00
E 03E0
E 8421
E 2A55
E 03E0
E 4210
E 7C00
E 2A55
D
W 0 02
A 12002010
B 20101200
E 4210
E 03E0
E 8421
E 2A55
E 8421
E 4210
E 7C00
E 2A55
D
W 0 01
A 7C0003E0
A 8421FFFF
A 00018000
A 2A554210
E 7C00
E 03E0
E 8421
E FFFF
E 0001
E 8000
E 2A55
E 4210
D

//--- all.f
+incdir+.
vdp_pkg.sv
vdp_regs.sv
vdp_pattern_layer.sv
vdp_mixer.sv
vdp_dot_path.sv
vdp_dot_path_props.sv
tb_vdp_dot_path.sv

//--- tb_vdp_dot_path.sv
// Trace-driven testbench for the dot path with credit word sources and a random-delay sink
`timescale 1ns/1ps
`include "vdp_macros.svh"

module tb_vdp_dot_path;
    import vdp_pkg::*;

    logic        CLK;
    logic        RESET_n;
    reg_wr_t     reg_wr;
    logic        word_a_valid;
    vram_word_u  word_a;
    logic        word_a_credit;
    logic        word_b_valid;
    vram_word_u  word_b;
    logic        word_b_credit;
    logic        dot_valid;
    rgb_t        dot;
    logic        dot_credit;

    // Trace records in file order
    logic [7:0]  rec_tag [$];
    logic [31:0] rec_v1 [$];
    logic [31:0] rec_v2 [$];

    // Words waiting for a credit
    logic [31:0] a_q [$];
    logic [31:0] b_q [$];
    // Colors still to arrive
    rgb_t        exp_q [$];
    // Cycles at which sink credits go back
    int          ret_q [$];

    int          cred_a = `VDP_WORD_FIFO;
    int          cred_b = `VDP_WORD_FIFO;
    int          cyc    = 0;
    int          limit  = 0;
    int          n_exp  = 0;
    int          n_dots = 0;
    logic [31:0] rng    = 32'h2334_f231;

    vdp_dot_path vdp_dot_path_i (.*);

    bind vdp_dot_path vdp_dot_path_props props_i (.*);

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic stop_on_error(input string msg);
        $display(">>> FAIL");
        $display("%s", msg);
        $fatal(1, "Run stopped at the first error");
    endtask

    // Next expected color from the trace
    // A surplus dot has nothing to match and only adds to the dot count
    task automatic check_color(input rgb_t got);
        rgb_t want;
        if (exp_q.size() != 0) begin
            want = exp_q.pop_front();
            if (got !== want) begin
                stop_on_error($sformatf("Fail at %0t: dot got %h expected %h",
                                        $time, got, want));
            end
        end
    endtask

    task automatic check_count(input string name, input int got, input int want);
        if (got != want) begin
            stop_on_error($sformatf("Fail at %0t: %s got %0d expected %0d",
                                    $time, name, got, want));
        end
    endtask

    // One register write, held for a single cycle
    task automatic write_reg(input logic [2:0] addr, input logic [7:0] data);
        @(negedge CLK);
        reg_wr      = '0;
        reg_wr.we   = 1'b1;
        reg_wr.addr = addr;
        reg_wr.data = data;
        @(negedge CLK);
        reg_wr.we = 1'b0;
    endtask

    // Wait until every queued word is sent and every expected dot is in
    task automatic drain();
        while (exp_q.size() != 0 || a_q.size() != 0 || b_q.size() != 0) begin
            @(negedge CLK);
        end
    endtask

    task automatic load_trace();
        int          fd;
        int          c;
        int          n;
        logic [7:0]  tag;
        logic [31:0] v1;
        logic [31:0] v2;
        fd = $fopen("vdp_trace.txt", "r");
        if (fd == 0) begin
            stop_on_error("Cannot open the trace file vdp_trace.txt");
        end else begin
            while ($fscanf(fd, " %c", tag) == 1) begin
                v1 = '0;
                v2 = '0;
                if (tag == "#") begin
                    // Comment up to end of line
                    c = $fgetc(fd);
                    while (c != "\n" && c != -1) begin
                        c = $fgetc(fd);
                    end
                end else if (tag == "W" || tag == "A" || tag == "B" || tag == "E" ||
                             tag == "D") begin
                    // Values still missing from the record
                    n = 0;
                    if (tag == "W") begin
                        n = 2 - $fscanf(fd, "%h %h", v1, v2);
                    end else if (tag != "D") begin
                        n = 1 - $fscanf(fd, "%h", v1);
                    end
                    if (n != 0) begin
                        stop_on_error($sformatf("Record %s in the trace is missing a value",
                                                tag));
                    end
                    rec_tag.push_back(tag);
                    rec_v1.push_back(v1);
                    rec_v2.push_back(v2);
                end else begin
                    stop_on_error($sformatf("Unknown record type %s in the trace", tag));
                end
            end
            $fclose(fd);
        end
    endtask

    // 20 ns clock
    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    // Cycle counter against the run limit
    initial begin
        forever begin
            @(posedge CLK);
            cyc++;
            if (limit > 0 && cyc > limit) begin
                stop_on_error($sformatf("Timeout: run still busy after %0d cycles", limit));
            end
        end
    end

    // Word sources, one word per credit
    initial begin
        word_a_valid = 1'b0;
        word_a       = '0;
        word_b_valid = 1'b0;
        word_b       = '0;
        forever begin
            @(negedge CLK);
            // Returned credits first
            if (word_a_credit) begin
                cred_a++;
            end
            if (word_b_credit) begin
                cred_b++;
            end
            if (a_q.size() > 0 && cred_a > 0) begin
                word_a_valid = 1'b1;
                word_a       = a_q.pop_front();
                cred_a--;
            end else begin
                word_a_valid = 1'b0;
            end
            if (b_q.size() > 0 && cred_b > 0) begin
                word_b_valid = 1'b1;
                word_b       = b_q.pop_front();
                cred_b--;
            end else begin
                word_b_valid = 1'b0;
            end
        end
    end

    // Sink, credit back 0 to 3 cycles after each dot
    initial begin
        int due;
        dot_credit = 1'b0;
        forever begin
            @(negedge CLK);
            if (dot_valid) begin
                check_color(dot);
                n_dots++;
                rng = xorshift32(rng);
                due = cyc + int'(rng[1:0]);
                // One pulse per cycle at most
                if (ret_q.size() > 0 && due <= ret_q[$]) begin
                    due = ret_q[$] + 1;
                end
                ret_q.push_back(due);
            end
            if (ret_q.size() > 0 && ret_q[0] <= cyc) begin
                dot_credit = 1'b1;
                void'(ret_q.pop_front());
            end else begin
                dot_credit = 1'b0;
            end
        end
    end

    // Trace player
    initial begin
        RESET_n = 1'b0;
        reg_wr  = '0;
        load_trace();
        limit = 40 * rec_tag.size() + 200;
        repeat (3) @(negedge CLK);
        RESET_n = 1'b1;
        foreach (rec_tag[i]) begin
            case (rec_tag[i])
                "W": write_reg(rec_v1[i][2:0], rec_v2[i][7:0]);
                "A": a_q.push_back(rec_v1[i]);
                "B": b_q.push_back(rec_v1[i]);
                "E": begin
                    exp_q.push_back(rgb_t'(rec_v1[i][15:0]));
                    n_exp++;
                end
                default: drain();
            endcase
        end
        // Final drain, then idle cycles to catch stray dots
        drain();
        repeat (10) @(negedge CLK);
        check_count("dot count", n_dots, n_exp);
        check_count("word_a credits", cred_a, `VDP_WORD_FIFO);
        check_count("word_b credits", cred_b, `VDP_WORD_FIFO);
        $display(">>> PASS");
        $finish;
    end

endmodule

//--- vdp_dot_path_props.sv
// Bound assertions on sink credit use and the reset state of the dot path outputs
`timescale 1ns/1ps
`include "vdp_macros.svh"

module vdp_dot_path_props (
    input logic CLK,
    input logic RESET_n,
    input logic dot_valid,
    input logic dot_credit,
    input logic word_a_credit,
    input logic word_b_credit
);

    // Dots at the sink whose credits have not come back
    logic [3:0] outstanding;

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            outstanding <= '0;
        end else begin
            outstanding <= outstanding + 4'(dot_valid) - 4'(dot_credit);
        end
    end

    // Never more dots than sink credits, a wrap from a stray credit fails too
    a_outstanding: assert property (
        @(posedge CLK) disable iff (!RESET_n) outstanding <= 4'(`VDP_OUT_CREDITS)
    ) else $error("More dots outstanding than sink credits");

    // Word credit pulses held off in reset
    a_word_credit_reset: assert property (
        @(posedge CLK) !RESET_n |-> (!word_a_credit && !word_b_credit)
    ) else $error("Word credit pulse while reset is held");

    // No dot while reset is held
    a_dot_valid_reset: assert property (
        @(posedge CLK) !RESET_n |-> !dot_valid
    ) else $error("dot_valid high while reset is held");

endmodule

//--- vdp_dot_path.sv
// Dot path top level joining the register file, both pattern layers and the mixer
`timescale 1ns/1ps

module vdp_dot_path (
    input  logic                CLK,
    input  logic                RESET_n,
    input  vdp_pkg::reg_wr_t    reg_wr,
    input  logic                word_a_valid,
    input  vdp_pkg::vram_word_u word_a,
    output logic                word_a_credit,
    input  logic                word_b_valid,
    input  vdp_pkg::vram_word_u word_b,
    output logic                word_b_credit,
    output logic                dot_valid,
    output vdp_pkg::rgb_t       dot,
    input  logic                dot_credit
);
    import vdp_pkg::*;

    // Control fan-out
    vdp_ctrl_t  ctrl;

    // Palette read between mixer and registers
    logic [5:0] pal_idx;
    rgb_t       pal_rgb;

    // Layer to mixer handshakes
    logic       a_ready;
    logic       a_take;
    layer_dot_t a_dot;
    logic       b_ready;
    logic       b_take;
    layer_dot_t b_dot;

    vdp_regs regs_i (
        .CLK,
        .RESET_n,
        .reg_wr,
        .ctrl,
        .pal_idx,
        .pal_rgb
    );

    // Layer A, bank from the low field
    vdp_pattern_layer layer_a (
        .CLK,
        .RESET_n,
        .ctrl,
        .bank        (ctrl.bank_a),
        .word_valid  (word_a_valid),
        .word        (word_a),
        .word_credit (word_a_credit),
        .dot_ready   (a_ready),
        .dot_out     (a_dot),
        .take        (a_take)
    );

    // Layer B, bank from the high field
    vdp_pattern_layer layer_b (
        .CLK,
        .RESET_n,
        .ctrl,
        .bank        (ctrl.bank_b),
        .word_valid  (word_b_valid),
        .word        (word_b),
        .word_credit (word_b_credit),
        .dot_ready   (b_ready),
        .dot_out     (b_dot),
        .take        (b_take)
    );

    vdp_mixer mixer_i (
        .CLK,
        .RESET_n,
        .ctrl,
        .a_ready,
        .a_dot,
        .a_take,
        .b_ready,
        .b_dot,
        .b_take,
        .pal_idx,
        .pal_rgb,
        .dot_valid,
        .dot,
        .dot_credit
    );

endmodule

//--- vdp_mixer.sv
// Dot mixer with layer priority, backdrop fill, palette lookup and sink credit counting
`timescale 1ns/1ps
`include "vdp_macros.svh"

module vdp_mixer (
    input  logic                CLK,
    input  logic                RESET_n,
    input  vdp_pkg::vdp_ctrl_t  ctrl,
    input  logic                a_ready,
    input  vdp_pkg::layer_dot_t a_dot,
    output logic                a_take,
    input  logic                b_ready,
    input  vdp_pkg::layer_dot_t b_dot,
    output logic                b_take,
    output logic [5:0]          pal_idx,
    input  vdp_pkg::rgb_t       pal_rgb,
    output logic                dot_valid,
    output vdp_pkg::rgb_t       dot,
    input  logic                dot_credit
);
    import vdp_pkg::*;

    localparam int CW = $clog2(`VDP_OUT_CREDITS + 1);

    // Sink credits still free
    logic [CW-1:0] credit_cnt;

    logic          bitmap;
    logic          take;

    // Layers ordered by the priority flag
    layer_dot_t    front;
    layer_dot_t    back;

    // First pipeline stage, lines up with the palette read
    logic          v1;
    rgb_t          bmp_d1;

    assign bitmap = (ctrl.mode == MODE_BITMAP);

    // Bitmap mode needs only layer A
    assign take   = (credit_cnt != '0) && a_ready && (bitmap || b_ready);
    assign a_take = take;
    assign b_take = take && !bitmap;

    assign front = ctrl.b_front ? b_dot : a_dot;
    assign back  = ctrl.b_front ? a_dot : b_dot;

    // Winning palette index
    // Backdrop when both layers are clear
    // Unused in bitmap mode
    always_comb begin
        if (!front.transp) begin
            pal_idx = front.idx;
        end else if (!back.transp) begin
            pal_idx = back.idx;
        end else begin
            pal_idx = ctrl.bdc;
        end
    end

    // Spent at take, returned by sink pulses
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            credit_cnt <= CW'(`VDP_OUT_CREDITS);
        end else begin
            credit_cnt <= credit_cnt - CW'(take) + CW'(dot_credit);
        end
    end

    // Two-stage valid pipeline
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            v1        <= 1'b0;
            dot_valid <= 1'b0;
        end else begin
            v1        <= take;
            dot_valid <= v1;
        end
    end

    // Direct color waits one stage beside the palette read
    always_ff @(posedge CLK) begin
        if (take) begin
            bmp_d1 <= a_dot.rgb;
        end
    end

    // Output color
    always_ff @(posedge CLK) begin
        if (v1) begin
            dot <= bitmap ? bmp_d1 : pal_rgb;
        end
    end

endmodule

//--- vdp_pattern_layer.sv
// Pattern layer that buffers video-RAM words with credit return and unpacks them into dots
`timescale 1ns/1ps
`include "vdp_macros.svh"

module vdp_pattern_layer (
    input  logic                CLK,
    input  logic                RESET_n,
    input  vdp_pkg::vdp_ctrl_t  ctrl,
    input  logic [1:0]          bank,
    input  logic                word_valid,
    input  vdp_pkg::vram_word_u word,
    output logic                word_credit,
    output logic                dot_ready,
    output vdp_pkg::layer_dot_t dot_out,
    input  logic                take
);
    import vdp_pkg::*;

    localparam int AW = $clog2(`VDP_WORD_FIFO);

    // Word FIFO
    vram_word_u    fifo_mem [`VDP_WORD_FIFO];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;

    // Dot position inside the head word
    logic [2:0]    dot_cnt;
    logic          last_dot;
    logic          pop;

    // Head word and its current nibble
    vram_word_u    head;
    logic [3:0]    nib;

    assign head      = fifo_mem[rd_ptr];
    assign nib       = head.nib[dot_cnt];
    assign dot_ready = (count != '0);

    // Two dots per word in bitmap mode, eight in pattern mode
    assign last_dot = (ctrl.mode == MODE_BITMAP) ? (dot_cnt == 3'd1) : (dot_cnt == 3'd7);
    // Word leaves once its last dot is taken
    assign pop      = take && last_dot;

    // Storage, source never writes without a credit
    always_ff @(posedge CLK) begin
        if (word_valid) begin
            fifo_mem[wr_ptr] <= word;
        end
    end

    // Pointers, fill level, dot counter and credit return
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            dot_cnt     <= '0;
            word_credit <= 1'b0;
        end else begin
            if (word_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + (AW+1)'(word_valid) - (AW+1)'(pop);
            if (take) begin
                dot_cnt <= last_dot ? 3'd0 : dot_cnt + 3'd1;
            end
            // One pulse, the cycle after the pop
            word_credit <= pop;
        end
    end

    // Decode the head word for the current dot
    always_comb begin
        if (ctrl.mode == MODE_BITMAP) begin
            // Upper color first, never transparent
            dot_out.transp = 1'b0;
            dot_out.idx    = '0;
            dot_out.rgb    = dot_cnt[0] ? head.bmp.lo : head.bmp.hi;
        end else begin
            // Zero nibble lets the layer behind show through
            dot_out.transp = (nib == 4'd0);
            dot_out.idx    = {bank, nib};
            dot_out.rgb    = '0;
        end
    end

endmodule

//--- vdp_regs.sv
// CPU register file with the palette RAM, its auto-increment write port and read port
`timescale 1ns/1ps
`include "vdp_macros.svh"

module vdp_regs (
    input  logic               CLK,
    input  logic               RESET_n,
    input  vdp_pkg::reg_wr_t   reg_wr,
    output vdp_pkg::vdp_ctrl_t ctrl,
    input  logic [5:0]         pal_idx,
    output vdp_pkg::rgb_t      pal_rgb
);
    import vdp_pkg::*;

    // Palette storage
    rgb_t       pal_mem [`VDP_PAL_SIZE];
    // Palette write pointer
    logic [5:0] pal_ptr;
    // Low byte held until the high byte arrives
    logic [7:0] pal_lo;

    // Per-register write strobes
    logic wr_mode;
    logic wr_bank;
    logic wr_bdc;
    logic wr_paddr;
    logic wr_plo;
    logic wr_phi;

    assign wr_mode  = reg_wr.we && (reg_wr.addr == `VDP_REG_MODE);
    assign wr_bank  = reg_wr.we && (reg_wr.addr == `VDP_REG_BANK);
    assign wr_bdc   = reg_wr.we && (reg_wr.addr == `VDP_REG_BDC);
    assign wr_paddr = reg_wr.we && (reg_wr.addr == `VDP_REG_PADDR);
    assign wr_plo   = reg_wr.we && (reg_wr.addr == `VDP_REG_PLO);
    assign wr_phi   = reg_wr.we && (reg_wr.addr == `VDP_REG_PHI);

    // Control fields
    // Reset leaves pattern mode with A in front
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            ctrl <= '0;
        end else begin
            if (wr_mode) begin
                ctrl.mode    <= dsp_mode_e'(reg_wr.data[0]);
                ctrl.b_front <= reg_wr.data[1];
            end
            // Bank A in the low pair, bank B in bits 5:4
            if (wr_bank) begin
                ctrl.bank_a <= reg_wr.data[1:0];
                ctrl.bank_b <= reg_wr.data[5:4];
            end
            if (wr_bdc) begin
                ctrl.bdc <= reg_wr.data[5:0];
            end
        end
    end

    // Palette pointer and low byte latch
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            pal_ptr <= '0;
            pal_lo  <= '0;
        end else begin
            if (wr_paddr) begin
                pal_ptr <= reg_wr.data[5:0];
            end else if (wr_phi) begin
                // Next entry after each full write
                pal_ptr <= pal_ptr + 6'd1;
            end
            if (wr_plo) begin
                pal_lo <= reg_wr.data;
            end
        end
    end

    // Palette entries, all black after reset
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            for (int i = 0; i < `VDP_PAL_SIZE; i++) begin
                pal_mem[i] <= '0;
            end
        end else if (wr_phi) begin
            pal_mem[pal_ptr] <= {reg_wr.data, pal_lo};
        end
    end

    // Read port, color one cycle after the index
    always_ff @(posedge CLK) begin
        pal_rgb <= pal_mem[pal_idx];
    end

endmodule

//--- vdp_pkg.sv
// Shared types of the dot path: colors, video-RAM word views, layer dots and control
package vdp_pkg;

    // Direct color, Ys flag on top
    typedef struct packed {
        logic       ys;
        logic [4:0] g;
        logic [4:0] r;
        logic [4:0] b;
    } rgb_t;

    // Bitmap view of one word
    // First color sits in the upper half
    typedef struct packed {
        rgb_t hi;
        rgb_t lo;
    } rgb_pair_t;

    // One video-RAM word
    // Pattern view has dot 0 in the top nibble
    typedef union packed {
        logic [0:7][3:0] nib;
        rgb_pair_t       bmp;
    } vram_word_u;

    // Dot offered by a layer to the mixer
    // Index is bank in bits 5:4, nibble in bits 3:0
    typedef struct packed {
        logic       transp;
        logic [5:0] idx;
        rgb_t       rgb;
    } layer_dot_t;

    // Display mode
    typedef enum logic {
        MODE_PATTERN = 1'b0,
        MODE_BITMAP  = 1'b1
    } dsp_mode_e;

    // Decoded control registers
    typedef struct packed {
        dsp_mode_e  mode;
        logic       b_front;
        logic [1:0] bank_a;
        logic [1:0] bank_b;
        logic [5:0] bdc;
    } vdp_ctrl_t;

    // CPU register write, upper bits reserved
    typedef struct packed {
        logic [4:0] rsvd;
        logic       we;
        logic [2:0] addr;
        logic [7:0] data;
    } reg_wr_t;

endpackage

//--- vdp_macros.svh
// Sizes, credit counts and register addresses of the dot path
`ifndef VDP_MACROS_SVH
`define VDP_MACROS_SVH

// Layer FIFO depth, also the initial credits of each word source
`define VDP_WORD_FIFO   4

// Initial credits toward the video sink
`define VDP_OUT_CREDITS 4

// Palette entries
`define VDP_PAL_SIZE    64

// CPU register addresses
`define VDP_REG_MODE    3'd0
`define VDP_REG_BANK    3'd1
`define VDP_REG_BDC     3'd2
`define VDP_REG_PADDR   3'd3
`define VDP_REG_PLO     3'd4
`define VDP_REG_PHI     3'd5

`endif
